// File: build.f
source/orb_pkg.sv
source/rx_frame_if.sv
source/rx_frame_reader.sv
source/reply_frame_builder.sv
source/tx_frame_buffer.sv
source/tx_frame_streamer.sv
source/orb_echo_top.sv
tb/tb_orb_echo.sv

// File: source/orb_echo_top.sv
// top level of the frame echo responder, sits between the MAC receive and transmit FIFOs
`timescale 1ns/100ps

module orb_echo_top
  import orb_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_n,
  // receive FIFOs
  input  logic       rx_len_empty_i,
  input  frame_len_t rx_len_data_i,
  output logic       rx_len_read_o,
  input  byte_t      rx_data_data_i,
  output logic       rx_data_read_o,
  // transmit FIFOs
  output byte_t      tx_data_data_o,
  output logic       tx_data_write_o,
  output frame_len_t tx_len_data_o,
  output logic       tx_len_write_o
);

  // ======================================================================
  // internal wiring
  // ======================================================================
  rx_frame_if frame_bus ();  // reader to builder byte stream

  logic       buf_wr_en;
  buf_addr_t  buf_wr_addr;
  byte_t      buf_wr_data;
  buf_addr_t  buf_rd_addr;
  byte_t      buf_rd_data;
  logic       send;
  frame_len_t send_len;
  logic       stream_busy;

  rx_frame_reader u_reader (
    .clk_i          (clk_i),
    .reset_n        (reset_n),
    .rx_len_empty_i (rx_len_empty_i),
    .rx_len_data_i  (rx_len_data_i),
    .rx_len_read_o  (rx_len_read_o),
    .rx_data_data_i (rx_data_data_i),
    .rx_data_read_o (rx_data_read_o),
    .frame_o        (frame_bus.reader)
  );

  reply_frame_builder u_builder (
    .clk_i         (clk_i),
    .reset_n       (reset_n),
    .frame_i       (frame_bus.builder),
    .buf_wr_en_o   (buf_wr_en),
    .buf_wr_addr_o (buf_wr_addr),
    .buf_wr_data_o (buf_wr_data),
    .send_o        (send),
    .send_len_o    (send_len),
    .stream_busy_i (stream_busy)
  );

  tx_frame_buffer u_buffer (
    .clk_i     (clk_i),
    .wr_en_i   (buf_wr_en),
    .wr_addr_i (buf_wr_addr),
    .wr_data_i (buf_wr_data),
    .rd_addr_i (buf_rd_addr),
    .rd_data_o (buf_rd_data)
  );

  tx_frame_streamer u_streamer (
    .clk_i           (clk_i),
    .reset_n         (reset_n),
    .send_i          (send),
    .send_len_i      (send_len),
    .busy_o          (stream_busy),
    .buf_rd_addr_o   (buf_rd_addr),
    .buf_rd_data_i   (buf_rd_data),
    .tx_data_data_o  (tx_data_data_o),
    .tx_data_write_o (tx_data_write_o),
    .tx_len_data_o   (tx_len_data_o),
    .tx_len_write_o  (tx_len_write_o)
  );

endmodule

// File: source/orb_pkg.sv
// shared widths, constants and state encodings for the frame echo responder; import into each block
package orb_pkg;

  // ======================================================================
  // data widths
  // ======================================================================
  typedef logic [7:0]  byte_t;       // one frame byte
  typedef logic [15:0] frame_len_t;  // frame length in bytes, as in the length FIFO word
  typedef logic [10:0] buf_addr_t;   // transmit buffer byte address
  typedef logic [47:0] mac_addr_t;   // ethernet MAC address
  typedef logic [15:0] ethertype_t;  // ethertype field at bytes 12 and 13

  // ======================================================================
  // protocol and sizing constants
  // ======================================================================
  localparam mac_addr_t  DEVICE_MAC    = 48'h001999cf95fa;  // our own MAC, source of every reply
  localparam ethertype_t ETHERTYPE_ARP = 16'h0806;
  localparam ethertype_t ETHERTYPE_IP  = 16'h0800;
  localparam frame_len_t ETH_HDR_LEN   = 16'd14;            // dst MAC + src MAC + ethertype
  localparam frame_len_t MAX_FRAME_LEN = 16'd1518;          // largest frame that gets echoed
  localparam int         BUF_DEPTH     = 2048;              // transmit RAM size in bytes

  // ======================================================================
  // state machines
  // ======================================================================
  typedef enum logic [2:0] {
    rx_idle,       // wait for a length word and a free builder
    rx_len_wait1,  // length FIFO read strobe is out
    rx_len_wait2,  // length word on the FIFO output, load it
    rx_pull,       // capture pending byte, issue next data read
    rx_wait        // data FIFO read strobe is out
  } rx_state_t;

  typedef enum logic [1:0] {
    bld_idle,     // no frame owned
    bld_payload,  // frame arriving, payload goes to RAM
    bld_header    // writing the 14 reply header bytes
  } build_state_t;

  typedef enum logic [1:0] {
    str_idle,   // nothing to send
    str_prime,  // first RAM read in flight
    str_push,   // one byte per cycle into the tx data FIFO
    str_len     // length word written
  } stream_state_t;

endpackage

// File: source/reply_frame_builder.sv
// assembles the echo reply in the transmit RAM and kicks the streamer once the frame is complete
`timescale 1ns/100ps

module reply_frame_builder
  import orb_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_n,
  rx_frame_if.builder frame_i,
  output logic        buf_wr_en_o,
  output buf_addr_t   buf_wr_addr_o,
  output byte_t       buf_wr_data_o,
  output logic        send_o,          // pulse, reply ready in RAM
  output frame_len_t  send_len_o,
  input  logic        stream_busy_i    // streamer still reading the RAM
);

  build_state_t state;
  mac_addr_t    dst_mac;    // received source MAC, becomes reply destination
  ethertype_t   ethertype;  // echoed unchanged
  logic [3:0]   hdr_cnt;    // header byte 0..13
  logic [111:0] hdr_bytes;  // reply header, byte 0 in the top bits
  logic         take_byte;  // payload byte accepted this cycle
  logic         in_header;

  assign hdr_bytes = {dst_mac, DEVICE_MAC, ethertype};
  assign take_byte = (state == bld_payload) && frame_i.byte_valid;
  assign in_header = (state == bld_header);

  // busy from frame_start until the streamer lets go, send_o covers the handover cycle
  assign frame_i.builder_ready = (state == bld_idle) && !send_o && !stream_busy_i;

  // ======================================================================
  // build control
  // ======================================================================
  always_ff @(posedge clk_i or negedge reset_n) begin
    if (!reset_n) begin
      state       <= bld_idle;
      hdr_cnt     <= '0;
      buf_wr_en_o <= 1'b0;
      send_o      <= 1'b0;
      send_len_o  <= '0;
    end else begin
      buf_wr_en_o <= 1'b0;
      send_o      <= 1'b0;

      case (state)
        bld_idle: begin
          if (frame_i.frame_start) state <= bld_payload;
        end

        bld_payload: begin
          // payload goes straight to its final address, header slots left for later
          if (frame_i.byte_valid && (frame_i.byte_index >= ETH_HDR_LEN) &&
              (frame_i.byte_index < BUF_DEPTH)) begin
            buf_wr_en_o <= 1'b1;
          end
          if (frame_i.frame_end) begin
            if (frame_i.frame_keep) begin
              hdr_cnt    <= '0;
              send_len_o <= frame_i.frame_len;
              state      <= bld_header;
            end else begin
              state <= bld_idle;  // dropped, bytes already drained
            end
          end
        end

        bld_header: begin
          buf_wr_en_o <= 1'b1;
          hdr_cnt     <= hdr_cnt + 4'd1;
          if (hdr_cnt == 4'd13) begin  // last header byte
            send_o <= 1'b1;
            state  <= bld_idle;
          end
        end

        default: state <= bld_idle;
      endcase
    end
  end

  // ======================================================================
  // header fields and RAM write bus
  // ======================================================================
  always_ff @(posedge clk_i) begin
    if (take_byte) begin
      if ((frame_i.byte_index >= 16'd6) && (frame_i.byte_index <= 16'd11)) begin
        dst_mac <= {dst_mac[39:0], frame_i.byte_data};  // shifts in MSB first
      end
      if ((frame_i.byte_index == 16'd12) || (frame_i.byte_index == 16'd13)) begin
        ethertype <= {ethertype[7:0], frame_i.byte_data};
      end
    end

    if (in_header) begin
      buf_wr_addr_o <= buf_addr_t'(hdr_cnt);
      buf_wr_data_o <= hdr_bytes[8 * (4'd13 - hdr_cnt) +: 8];
    end else if (take_byte) begin
      buf_wr_addr_o <= buf_addr_t'(frame_i.byte_index);
      buf_wr_data_o <= frame_i.byte_data;
    end
  end

  // the RAM holds a single frame, a write during streaming corrupts the reply
  a_no_write_while_streaming: assert property (@(posedge clk_i) disable iff (!reset_n)
    buf_wr_en_o |-> !stream_busy_i)
    else $error("transmit RAM written while streamer busy");

endmodule

// File: source/rx_frame_if.sv
// decoded receive byte stream between frame reader and reply builder; instantiate once per echo path
`timescale 1ns/100ps

interface rx_frame_if
  import orb_pkg::*;
();

  logic       frame_start;    // pulse, new length loaded
  logic       byte_valid;     // strobe, one per received byte
  byte_t      byte_data;      // received byte
  frame_len_t byte_index;     // position of byte_data in the frame
  frame_len_t frame_len;      // held from frame_start
  logic       frame_end;      // pulse, cycle after the last byte strobe
  logic       frame_keep;     // sampled with frame_end, ARP or IP and in range
  logic       builder_ready;  // level, builder and streamer both free

  modport reader (
    output frame_start, byte_valid, byte_data, byte_index,
    output frame_len, frame_end, frame_keep,
    input  builder_ready
  );

  modport builder (
    input  frame_start, byte_valid, byte_data, byte_index,
    input  frame_len, frame_end, frame_keep,
    output builder_ready
  );

endinterface

// File: source/rx_frame_reader.sv
// pulls frames out of the receive length and data FIFOs and hands them on as a byte stream
`timescale 1ns/100ps

module rx_frame_reader
  import orb_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_n,
  input  logic       rx_len_empty_i,   // length FIFO empty
  input  frame_len_t rx_len_data_i,    // length word, valid the cycle after the read
  output logic       rx_len_read_o,
  input  byte_t      rx_data_data_i,   // data byte, valid the cycle after the read
  output logic       rx_data_read_o,
  rx_frame_if.reader frame_o
);

  rx_state_t  state;
  frame_len_t len_cnt;    // bytes not yet requested from the data FIFO
  frame_len_t idx_cnt;    // index of the next byte to capture
  logic       byte_pend;  // a data read is out, byte due this cycle in rx_pull
  ethertype_t ethertype;  // captured from bytes 12 and 13
  logic       type_ok;
  logic       len_ok;

  // keep decision, only ARP and IPv4 frames of sane length get echoed
  assign type_ok = (ethertype == ETHERTYPE_ARP) || (ethertype == ETHERTYPE_IP);
  assign len_ok  = (frame_o.frame_len >= ETH_HDR_LEN) && (frame_o.frame_len <= MAX_FRAME_LEN);

  // ======================================================================
  // receive control FSM
  // ======================================================================
  always_ff @(posedge clk_i or negedge reset_n) begin
    if (!reset_n) begin
      state               <= rx_idle;
      rx_len_read_o       <= 1'b0;
      rx_data_read_o      <= 1'b0;
      len_cnt             <= '0;
      idx_cnt             <= '0;
      byte_pend           <= 1'b0;
      ethertype           <= '0;
      frame_o.frame_start <= 1'b0;
      frame_o.byte_valid  <= 1'b0;
      frame_o.byte_data   <= '0;
      frame_o.byte_index  <= '0;
      frame_o.frame_len   <= '0;
      frame_o.frame_end   <= 1'b0;
      frame_o.frame_keep  <= 1'b0;
    end else begin
      rx_len_read_o       <= 1'b0;  // strobes default low
      rx_data_read_o      <= 1'b0;
      frame_o.frame_start <= 1'b0;
      frame_o.byte_valid  <= 1'b0;
      frame_o.frame_end   <= 1'b0;

      case (state)
        rx_idle: begin
          if (!rx_len_empty_i && frame_o.builder_ready) begin  // only one frame in flight
            rx_len_read_o <= 1'b1;
            state         <= rx_len_wait1;
          end
        end

        rx_len_wait1: state <= rx_len_wait2;  // FIFO output settles

        rx_len_wait2: begin
          frame_o.frame_len   <= rx_len_data_i;
          len_cnt             <= rx_len_data_i;
          idx_cnt             <= '0;
          frame_o.frame_start <= 1'b1;
          state               <= rx_pull;
        end

        rx_pull: begin
          if (byte_pend) begin  // byte requested two cycles ago is on the bus now
            frame_o.byte_data  <= rx_data_data_i;
            frame_o.byte_index <= idx_cnt;
            frame_o.byte_valid <= 1'b1;
            idx_cnt            <= idx_cnt + 16'd1;
            byte_pend          <= 1'b0;
            if (idx_cnt == 16'd12) ethertype[15:8] <= rx_data_data_i;
            if (idx_cnt == 16'd13) ethertype[7:0]  <= rx_data_data_i;
          end
          if (len_cnt != '0) begin
            rx_data_read_o <= 1'b1;       // request next byte
            len_cnt        <= len_cnt - 16'd1;
            byte_pend      <= 1'b1;
            state          <= rx_wait;
          end else if (!byte_pend) begin  // last strobe went out last cycle
            frame_o.frame_end  <= 1'b1;
            frame_o.frame_keep <= type_ok && len_ok;
            state              <= rx_idle;
          end
        end

        rx_wait: state <= rx_pull;  // data read strobe is high this cycle

        default: state <= rx_idle;
      endcase
    end
  end

  // ======================================================================
  // checks
  // ======================================================================
  a_one_fifo_read: assert property (@(posedge clk_i) disable iff (!reset_n)
    !(rx_len_read_o && rx_data_read_o))
    else $error("length and data FIFO read together");

  a_byte_spacing: assert property (@(posedge clk_i) disable iff (!reset_n)
    frame_o.byte_valid |=> !frame_o.byte_valid)
    else $error("byte_valid high in consecutive cycles");

endmodule

// File: source/tx_frame_buffer.sv
// single-frame transmit RAM, written by the builder and read back by the streamer
`timescale 1ns/100ps

module tx_frame_buffer
  import orb_pkg::*;
(
  input  logic      clk_i,
  input  logic      wr_en_i,
  input  buf_addr_t wr_addr_i,
  input  byte_t     wr_data_i,
  input  buf_addr_t rd_addr_i,
  output byte_t     rd_data_o   // one cycle after rd_addr_i
);

  byte_t mem [BUF_DEPTH];  // one reply frame

  // write port
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // registered read port, maps onto block RAM
  always_ff @(posedge clk_i) begin
    rd_data_o <= mem[rd_addr_i];
  end

endmodule

// File: source/tx_frame_streamer.sv
// copies a finished reply from the transmit RAM into the tx data FIFO, then writes its length word
`timescale 1ns/100ps

module tx_frame_streamer
  import orb_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_n,
  input  logic       send_i,           // pulse, frame in RAM from address 0
  input  frame_len_t send_len_i,
  output logic       busy_o,
  output buf_addr_t  buf_rd_addr_o,
  input  byte_t      buf_rd_data_i,    // one cycle behind buf_rd_addr_o
  output byte_t      tx_data_data_o,
  output logic       tx_data_write_o,
  output frame_len_t tx_len_data_o,
  output logic       tx_len_write_o
);

  stream_state_t state;
  frame_len_t    len_cnt;  // bytes still to push

  assign busy_o         = (state != str_idle);
  assign tx_data_data_o = buf_rd_data_i;  // RAM output lines up with the write strobe

  // ======================================================================
  // transmit control FSM
  // ======================================================================
  always_ff @(posedge clk_i or negedge reset_n) begin
    if (!reset_n) begin
      state           <= str_idle;
      len_cnt         <= '0;
      buf_rd_addr_o   <= '0;
      tx_data_write_o <= 1'b0;
      tx_len_data_o   <= '0;
      tx_len_write_o  <= 1'b0;
    end else begin
      tx_data_write_o <= 1'b0;
      tx_len_write_o  <= 1'b0;

      case (state)
        str_idle: begin
          if (send_i) begin
            len_cnt       <= send_len_i;
            tx_len_data_o <= send_len_i;  // held until the length write
            buf_rd_addr_o <= '0;
            state         <= str_prime;
          end
        end

        // prime cycle covers the RAM read latency, both then run the same step
        str_prime, str_push: begin
          if (len_cnt != '0) begin
            tx_data_write_o <= 1'b1;
            len_cnt         <= len_cnt - 16'd1;
            buf_rd_addr_o   <= buf_rd_addr_o + 11'd1;
            state           <= str_push;
          end else begin
            tx_len_write_o <= 1'b1;  // one cycle after the last byte
            state          <= str_len;
          end
        end

        str_len: state <= str_idle;

        default: state <= str_idle;
      endcase
    end
  end

  // builder must wait for busy_o to drop before handing over the next frame
  a_no_send_while_busy: assert property (@(posedge clk_i) disable iff (!reset_n)
    send_i |-> !busy_o)
    else $error("send while streamer busy");

endmodule

// File: tb/tb_orb_echo.sv
// directed testbench for the frame echo responder that models the rx and tx FIFOs and scores each reply
`timescale 1ns/100ps

module tb_orb_echo
  import orb_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 20000;  // longest test is the 1600-byte drain plus random set
  localparam int QUIET_CYCLES   = 40;     // idle gap that marks a finished test

  logic       clk_i;
  logic       reset_n;
  logic       rx_len_empty_i;
  frame_len_t rx_len_data_i;
  logic       rx_len_read_o;
  byte_t      rx_data_data_i;
  logic       rx_data_read_o;
  byte_t      tx_data_data_o;
  logic       tx_data_write_o;
  frame_len_t tx_len_data_o;
  logic       tx_len_write_o;

  frame_len_t  len_q[$];      // receive length FIFO
  byte_t       data_q[$];     // receive data FIFO
  byte_t       out_q[$];      // captured tx data bytes
  frame_len_t  out_len_q[$];  // captured tx length words
  int          out_cnt_q[$];  // data bytes seen before each length word
  byte_t       exp_q[$];      // expected bytes of all replies back to back
  frame_len_t  exp_len_q[$];
  int          bytes_since_len;
  int          strobe_cnt;    // any FIFO strobe seen
  int          overlap_cnt;   // data and length write in one cycle
  int          cycle_cnt;
  int          test_errs;
  int          err_total;
  int          tests_run;
  int          tests_failed;
  logic [31:0] lcg_state;

  orb_echo_top i_dut (.*);

  // ======================================================================
  // clock, FIFO models, monitors
  // ======================================================================
  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    #1;  // DUT outputs have settled
    if (rx_len_read_o && (len_q.size() > 0)) rx_len_data_i <= len_q.pop_front();
    if (rx_data_read_o && (data_q.size() > 0)) rx_data_data_i <= data_q.pop_front();
    rx_len_empty_i <= (len_q.size() == 0);
    if (rx_len_read_o || rx_data_read_o || tx_data_write_o || tx_len_write_o) strobe_cnt++;
    if (tx_data_write_o && tx_len_write_o) overlap_cnt++;
    if (tx_data_write_o) begin
      out_q.push_back(tx_data_data_o);
      bytes_since_len++;
    end
    if (tx_len_write_o) begin
      out_len_q.push_back(tx_len_data_o);
      out_cnt_q.push_back(bytes_since_len);  // frame boundary in the data stream
      bytes_since_len = 0;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the DUT stopped making progress", cycle_cnt);
      $display("Test failures found");
      $finish;
    end
  end

  // ======================================================================
  // helpers
  // ======================================================================
  function automatic byte_t next_rand_byte();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];  // middle bits of the new state
  endfunction

  // queue one frame into the rx FIFOs and record the reply it must produce
  task automatic send_frame(input ethertype_t etype, input int len);
    byte_t f[$];
    byte_t b;
    bit    keep;
    for (int i = 0; i < len; i++) begin
      b = next_rand_byte();
      if (i == 12) b = etype[15:8];
      if (i == 13) b = etype[7:0];
      f.push_back(b);
    end
    keep = ((etype == 16'h0806) || (etype == 16'h0800)) && (len >= 14) && (len <= 1518);
    if (keep) begin
      for (int i = 0; i < 6; i++) exp_q.push_back(f[6 + i]);  // sender becomes destination
      for (int i = 0; i < 6; i++) exp_q.push_back(DEVICE_MAC[47 - 8 * i -: 8]);
      for (int i = 12; i < len; i++) exp_q.push_back(f[i]);   // ethertype and payload as is
      exp_len_q.push_back(frame_len_t'(len));
    end
    @(posedge clk_i);
    #2;  // clear of the FIFO model update
    foreach (f[i]) data_q.push_back(f[i]);
    len_q.push_back(frame_len_t'(len));
  endtask

  // all frames drained, all replies out, then a quiet stretch
  task automatic wait_done();
    int quiet;
    quiet = 0;
    while (quiet < QUIET_CYCLES) begin
      @(posedge clk_i);
      #2;
      if ((len_q.size() == 0) && (data_q.size() == 0) && !tx_data_write_o &&
          !tx_len_write_o && (out_len_q.size() >= exp_len_q.size())) begin
        quiet++;
      end else begin
        quiet = 0;
      end
    end
  endtask

  task automatic check_replies();
    int n;
    int byte_errs;
    n = (out_len_q.size() < exp_len_q.size()) ? out_len_q.size() : exp_len_q.size();
    byte_errs = 0;
    if (out_len_q.size() != exp_len_q.size()) begin
      $display("expected %0d replies but saw %0d", exp_len_q.size(), out_len_q.size());
      test_errs++;
    end
    if (overlap_cnt != 0) begin
      $display("data and length writes happened in the same cycle");
      test_errs++;
    end
    for (int r = 0; r < n; r++) begin
      if (out_len_q[r] != exp_len_q[r]) begin
        $display("FAIL tx_len_data_o reply %0d expected %h got %h", r, exp_len_q[r],
                 out_len_q[r]);
        test_errs++;
      end
      if (out_cnt_q[r] != int'(exp_len_q[r])) begin
        $display("reply %0d had %0d data bytes before its length word instead of %0d", r,
                 out_cnt_q[r], exp_len_q[r]);
        test_errs++;
      end
    end
    if (out_q.size() != exp_q.size()) begin
      $display("expected %0d transmitted bytes but saw %0d", exp_q.size(), out_q.size());
      test_errs++;
    end
    for (int i = 0; (i < out_q.size()) && (i < exp_q.size()); i++) begin
      if ((out_q[i] != exp_q[i]) && (byte_errs < 8)) begin
        $display("FAIL tx_data_data_o stream byte %0d expected %h got %h", i, exp_q[i],
                 out_q[i]);
        byte_errs++;
        test_errs++;
      end
    end
    out_q.delete();
    out_len_q.delete();
    out_cnt_q.delete();
    exp_q.delete();
    exp_len_q.delete();
    overlap_cnt = 0;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    err_total += test_errs;
    if (test_errs != 0) tests_failed++;
    $display("test %0s: %0s (%0d errors)", name, (test_errs == 0) ? "ok" : "failed", test_errs);
    test_errs = 0;
  endtask

  // ======================================================================
  // directed tests
  // ======================================================================
  task automatic idle_after_reset();
    strobe_cnt = 0;
    repeat (50) @(posedge clk_i);
    if (strobe_cnt != 0) begin
      $display("a FIFO strobe went high %0d times with nothing queued", strobe_cnt);
      test_errs++;
    end
    finish_test("idle_after_reset");
  endtask

  task automatic echo_one_frame(input ethertype_t etype, input int len, input string name);
    send_frame(etype, len);
    wait_done();
    check_replies();
    finish_test(name);
  endtask

  // the 10-byte frame carries no ethertype, it follows an IPv4 frame so only its length drops it
  task automatic drop_then_echo();
    send_frame(16'h0800, 1600);  // longer than the largest frame
    send_frame(16'h0800, 10);    // shorter than the header
    send_frame(16'h86dd, 60);    // unknown ethertype
    send_frame(16'h0800, 64);    // must still line up after the drains
    wait_done();
    check_replies();
    finish_test("drop_then_echo");
  endtask

  task automatic random_burst();
    ethertype_t etype;
    int         len;
    int         kind;
    for (int k = 0; k < 5; k++) begin
      kind = k % 3;  // IPv4, ARP and unknown in turn
      len  = 14 + ({next_rand_byte(), next_rand_byte()} % 240);
      etype = (kind == 0) ? 16'h0800 : (kind == 1) ? 16'h0806 : 16'h86dd;
      send_frame(etype, len);
    end
    wait_done();
    check_replies();
    finish_test("random_burst");
  endtask

  initial begin
    reset_n         = 1'b0;
    rx_len_empty_i  = 1'b1;
    rx_len_data_i   = '0;
    rx_data_data_i  = '0;
    lcg_state       = 32'h2230;
    bytes_since_len = 0;
    strobe_cnt      = 0;
    overlap_cnt     = 0;
    cycle_cnt       = 0;
    test_errs       = 0;
    err_total       = 0;
    tests_run       = 0;
    tests_failed    = 0;
    repeat (8) @(posedge clk_i);
    #1 reset_n = 1'b1;

    idle_after_reset();
    echo_one_frame(16'h0800, 60, "ipv4_echo_60");
    echo_one_frame(16'h0806, 42, "arp_echo_42");
    drop_then_echo();
    random_burst();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_total);
    if (err_total == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
